// File: flist.f
hdl/hmem_pkg.sv
hdl/avmm_reg_stage.sv
hdl/burst_splitter.sv
hdl/wr_rsp_filter.sv
hdl/shim_ctrl.sv
hdl/host_mem_avalon_shim.sv
sim/tb_clk_gen.sv
sim/fiu_mem_model.sv
sim/tb_host_mem_shim.sv

// File: run_sim.sh
#!/bin/sh
# Builds the shim and its testbench with Verilator, runs the simulation
# and fails when the log reports a failed test
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_host_mem_shim \
    -f flist.f \
    -o sim_host_mem_shim

./obj_dir/sim_host_mem_shim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log
then
    exit 1
fi

// File: sim/tb_host_mem_shim.sv
/*
 * Testbench for the host-memory shim. A table of AFU read and write bursts is
 * applied in order; read data, FIU chunking, write responses and the written
 * beats are checked against the expected values of each entry.
 */
`timescale 1ns/1ps

module tb_host_mem_shim
    import hmem_pkg::*;
();

    localparam int FIU_MAX_BURST = 4;
    localparam int TAG_DEPTH     = 16;
    localparam int WAIT_LIMIT    = 2000;

    // One table entry, also used for each FIU chunk that is observed
    typedef struct packed {
        logic   is_write;
        addr_t  addr;
        burst_t burst;
    } xfer_t;

    logic         clk;
    logic         arst_n;
    avmm_cmd_t    afu_cmd;
    logic         afu_waitrequest;
    avmm_rd_rsp_t afu_rd_rsp;
    logic         afu_wr_rsp_valid;
    avmm_cmd_t    fiu_cmd;
    logic         fiu_waitrequest;
    avmm_rd_rsp_t fiu_rd_rsp;
    logic         fiu_wr_rsp_valid;

    xfer_t stim_table [$];
    data_t rd_data_q [$];
    xfer_t chunk_q [$];
    xfer_t fiu_seen;
    int    afu_wr_rsp_count = 0;
    int    fiu_wr_left = 0;
    int    error_count;
    int    timeout_count;
    int    rd_expected;
    int    chunk_expected;
    int    wr_rsp_expected;
    int    wr_beats_expected;

    tb_clk_gen #(
        .HALF_PERIOD_NS (4),
        .RESET_CYCLES   (10)
    ) u_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    fiu_mem_model #(
        .SEED (32'h6226_0e02)
    ) u_mem (
        .clk              (clk),
        .arst_n           (arst_n),
        .fiu_cmd          (fiu_cmd),
        .fiu_waitrequest  (fiu_waitrequest),
        .fiu_rd_rsp       (fiu_rd_rsp),
        .fiu_wr_rsp_valid (fiu_wr_rsp_valid)
    );

    host_mem_avalon_shim #(
        .FIU_MAX_BURST (FIU_MAX_BURST),
        .TAG_DEPTH     (TAG_DEPTH)
    ) u_dut (
        .clk              (clk),
        .arst_n           (arst_n),
        .afu_cmd          (afu_cmd),
        .afu_waitrequest  (afu_waitrequest),
        .afu_rd_rsp       (afu_rd_rsp),
        .afu_wr_rsp_valid (afu_wr_rsp_valid),
        .fiu_cmd          (fiu_cmd),
        .fiu_waitrequest  (fiu_waitrequest),
        .fiu_rd_rsp       (fiu_rd_rsp),
        .fiu_wr_rsp_valid (fiu_wr_rsp_valid)
    );

    // ========================================
    // Expected data rules
    // ========================================

    // The FIU model answers reads with this function of the address
    function automatic data_t expected_rd_data(input addr_t a);
        return {a ^ 32'hC3A5_0F96, a * 32'h9E37_79B1};
    endfunction

    // Write beats carry their own target address in both halves
    function automatic data_t wr_pattern(input addr_t a);
        return {~a, a + 32'h1357_9BDF};
    endfunction

    function automatic xfer_t make_xfer(input logic is_write, input addr_t a, input burst_t n);
        xfer_t x;
        x.is_write = is_write;
        x.addr     = a;
        x.burst    = n;
        return x;
    endfunction

    // ========================================
    // Compare tasks
    // ========================================
    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp)
        begin
            error_count++;
            $display("FAILED @ %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_burst(input string name, input burst_t got, input burst_t exp);
        if (got !== exp)
        begin
            error_count++;
            $display("FAILED @ %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp)
        begin
            error_count++;
            $display("FAILED @ %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            error_count++;
            $display("FAILED @ %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            error_count++;
            $display("FAILED @ %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("Timeout @ %0t ns: %s", $time, what);
    endtask

    // ========================================
    // Monitors
    // ========================================

    // Outputs are sampled mid-cycle where they hold the values seen at the next edge
    always @(negedge clk)
    begin
        if (!arst_n)
        begin
            fiu_wr_left = 0;
        end
        else
        begin
            if (afu_rd_rsp.readdatavalid)
            begin
                rd_data_q.push_back(afu_rd_rsp.readdata);
            end
            if (afu_wr_rsp_valid)
            begin
                afu_wr_rsp_count++;
            end
            if (fiu_cmd.read && !fiu_waitrequest)
            begin
                fiu_seen = make_xfer(1'b0, fiu_cmd.address, fiu_cmd.burstcount);
                chunk_q.push_back(fiu_seen);
            end
            // Only the first beat of a write chunk opens a new chunk
            if (fiu_cmd.write && !fiu_waitrequest)
            begin
                if (fiu_wr_left == 0)
                begin
                    fiu_seen = make_xfer(1'b1, fiu_cmd.address, fiu_cmd.burstcount);
                    chunk_q.push_back(fiu_seen);
                    fiu_wr_left = int'(fiu_cmd.burstcount);
                end
                fiu_wr_left--;
            end
        end
    end

    // ========================================
    // Stimulus
    // ========================================
    task automatic load_table();
        stim_table.push_back(make_xfer(1'b0, 32'h0000_1000, 8'd1));
        stim_table.push_back(make_xfer(1'b0, 32'h0000_1010, 8'd3));
        stim_table.push_back(make_xfer(1'b0, 32'h0000_1020, 8'd4));
        stim_table.push_back(make_xfer(1'b1, 32'h0000_2000, 8'd5));
        stim_table.push_back(make_xfer(1'b1, 32'h0000_2040, 8'd9));
        stim_table.push_back(make_xfer(1'b0, 32'h0000_3000, 8'd16));
        stim_table.push_back(make_xfer(1'b1, 32'h0000_2080, 8'd1));
        stim_table.push_back(make_xfer(1'b1, 32'h0000_2100, 8'd16));
        stim_table.push_back(make_xfer(1'b0, 32'h0000_3100, 8'd9));
        stim_table.push_back(make_xfer(1'b1, 32'h0000_2200, 8'd3));
        stim_table.push_back(make_xfer(1'b0, 32'h0000_3200, 8'd5));
        stim_table.push_back(make_xfer(1'b1, 32'h0000_2300, 8'd4));
    endtask

    // Presents one beat and holds it until an edge with waitrequest low
    task automatic send_beat(input avmm_cmd_t cmd);
        int cycles;
        cycles = 0;
        afu_cmd <= cmd;
        do
        begin
            @(posedge clk);
            cycles++;
        end
        while (afu_waitrequest && cycles < WAIT_LIMIT);
        if (afu_waitrequest)
        begin
            report_timeout("AFU command beat was never accepted");
        end
    endtask

    task automatic wait_rd_beats(input int total);
        int cycles;
        cycles = 0;
        while (rd_data_q.size() < total && cycles < WAIT_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (rd_data_q.size() < total)
        begin
            report_timeout("read data beats missing on afu_rd_rsp");
        end
    endtask

    task automatic wait_wr_rsp(input int total);
        int cycles;
        cycles = 0;
        while (afu_wr_rsp_count < total && cycles < WAIT_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (afu_wr_rsp_count < total)
        begin
            report_timeout("no write response on afu_wr_rsp_valid");
        end
    endtask

    // FIU chunks must be full-size except a trailing remainder
    task automatic check_chunks(input xfer_t e, input int base);
        addr_t exp_addr;
        int    remain;
        int    size;
        int    k;
        exp_addr = e.addr;
        remain   = int'(e.burst);
        k        = base;
        while (remain > 0)
        begin
            size = (remain > FIU_MAX_BURST) ? FIU_MAX_BURST : remain;
            if (k < chunk_q.size())
            begin
                check_bit("fiu_cmd.write of chunk", chunk_q[k].is_write, e.is_write);
                check_addr("fiu_cmd.address", chunk_q[k].addr, exp_addr);
                check_burst("fiu_cmd.burstcount", chunk_q[k].burst, burst_t'(size));
            end
            exp_addr = exp_addr + addr_t'(size);
            remain   = remain - size;
            k++;
        end
        chunk_expected = k;
        check_count("FIU chunk count", chunk_q.size(), chunk_expected);
    endtask

    task automatic run_entry(input xfer_t e);
        avmm_cmd_t cmd;
        int        n;
        int        i;
        int        chunk_base;
        n          = int'(e.burst);
        chunk_base = chunk_q.size();
        // Stray beats or pulses left over from earlier entries show up here
        check_count("afu_rd_rsp beats so far", rd_data_q.size(), rd_expected);
        check_count("afu_wr_rsp_valid pulses so far", afu_wr_rsp_count, wr_rsp_expected);
        cmd            = '0;
        cmd.address    = e.addr;
        cmd.burstcount = e.burst;
        if (!e.is_write)
        begin
            cmd.read = 1'b1;
            send_beat(cmd);
            afu_cmd <= '0;
            rd_expected += n;
            if (timeout_count == 0)
            begin
                wait_rd_beats(rd_expected);
            end
            if (timeout_count == 0)
            begin
                for (i = 0; i < n; i++)
                begin
                    check_data("afu_rd_rsp.readdata", rd_data_q[rd_expected - n + i],
                               expected_rd_data(e.addr + addr_t'(i)));
                end
            end
        end
        else
        begin
            cmd.write = 1'b1;
            i = 0;
            while (i < n && timeout_count == 0)
            begin
                cmd.writedata = wr_pattern(e.addr + addr_t'(i));
                send_beat(cmd);
                i++;
            end
            afu_cmd <= '0;
            wr_rsp_expected++;
            if (timeout_count == 0)
            begin
                wait_wr_rsp(wr_rsp_expected);
            end
            if (timeout_count == 0)
            begin
                for (i = 0; i < n; i++)
                begin
                    check_addr("FIU write beat address",
                               u_mem.wr_addr_log[wr_beats_expected + i], e.addr + addr_t'(i));
                    check_data("fiu_cmd.writedata", u_mem.wr_data_log[wr_beats_expected + i],
                               wr_pattern(e.addr + addr_t'(i)));
                end
            end
            wr_beats_expected += n;
        end
        if (timeout_count == 0)
        begin
            check_chunks(e, chunk_base);
            check_count("FIU write beats stored", u_mem.wr_count, wr_beats_expected);
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial
    begin
        int cycles;
        error_count       = 0;
        timeout_count     = 0;
        rd_expected       = 0;
        chunk_expected    = 0;
        wr_rsp_expected   = 0;
        wr_beats_expected = 0;
        cycles            = 0;
        afu_cmd <= '0;
        load_table();

        do
        begin
            @(posedge clk);
            cycles++;
        end
        while (!arst_n && cycles < WAIT_LIMIT);
        if (!arst_n)
        begin
            report_timeout("reset was never released");
        end

        // The FIU side and the write response are quiet right after reset
        @(negedge clk);
        check_bit("fiu_cmd.read", fiu_cmd.read, 1'b0);
        check_bit("fiu_cmd.write", fiu_cmd.write, 1'b0);
        check_bit("afu_wr_rsp_valid", afu_wr_rsp_valid, 1'b0);
        @(posedge clk);

        for (int e = 0; e < stim_table.size(); e++)
        begin
            if (timeout_count == 0)
            begin
                run_entry(stim_table[e]);
            end
        end

        if (timeout_count == 0)
        begin
            check_count("afu_rd_rsp beats in total", rd_data_q.size(), rd_expected);
            check_count("afu_wr_rsp_valid pulses in total", afu_wr_rsp_count, wr_rsp_expected);
        end

        $display("Run finished with %0d errors and %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: sim/fiu_mem_model.sv
/*
 * Host memory behind the FIU port. It throws random waitrequest, returns read
 * data as a fixed function of the line address and logs every write beat.
 */
`timescale 1ns/1ps

module fiu_mem_model
    import hmem_pkg::*;
#(
    parameter int unsigned SEED = 32'h1
)
(
    input  logic         clk,
    input  logic         arst_n,
    input  avmm_cmd_t    fiu_cmd,
    output logic         fiu_waitrequest,
    output avmm_rd_rsp_t fiu_rd_rsp,
    output logic         fiu_wr_rsp_valid
);

    addr_t        rd_pending [$];
    addr_t        wr_addr;
    int           wr_left;
    int           wr_count;
    int           beat;
    logic         wr_done;
    avmm_rd_rsp_t rd_beat;

    // Every write beat in arrival order for the testbench to check
    addr_t        wr_addr_log [$];
    data_t        wr_data_log [$];

    // Read data depends on every address bit
    function automatic data_t line_data(input addr_t a);
        return {a ^ 32'hC3A5_0F96, a * 32'h9E37_79B1};
    endfunction

    initial
    begin
        void'($urandom(SEED));
        wr_left  = 0;
        wr_count = 0;
        wr_addr  = '0;
        fiu_waitrequest  <= 1'b0;
        fiu_rd_rsp       <= '0;
        fiu_wr_rsp_valid <= 1'b0;
        forever
        begin
            @(posedge clk);
            wr_done = 1'b0;
            rd_beat = '0;
            if (!arst_n)
            begin
                rd_pending.delete();
                wr_left = 0;
            end
            else
            begin
                // Accepted read chunk queues one address per beat
                if (fiu_cmd.read && !fiu_waitrequest)
                begin
                    for (beat = 0; beat < int'(fiu_cmd.burstcount); beat++)
                    begin
                        rd_pending.push_back(fiu_cmd.address + addr_t'(beat));
                    end
                end
                // The first beat of a write chunk carries its address and size
                if (fiu_cmd.write && !fiu_waitrequest)
                begin
                    if (wr_left == 0)
                    begin
                        wr_addr = fiu_cmd.address;
                        wr_left = int'(fiu_cmd.burstcount);
                    end
                    wr_addr_log.push_back(wr_addr);
                    wr_data_log.push_back(fiu_cmd.writedata);
                    wr_count++;
                    wr_addr = wr_addr + 1'b1;
                    wr_left--;
                    // One response per chunk, after its last beat
                    wr_done = (wr_left == 0);
                end
                if (rd_pending.size() > 0)
                begin
                    rd_beat.readdatavalid = 1'b1;
                    rd_beat.readdata      = line_data(rd_pending.pop_front());
                end
            end
            fiu_rd_rsp       <= rd_beat;
            fiu_wr_rsp_valid <= wr_done;
            if (arst_n && (($urandom % 32'd8) < 32'd3))
            begin
                fiu_waitrequest <= 1'b1;
            end
            else
            begin
                fiu_waitrequest <= 1'b0;
            end
        end
    end

endmodule

// File: sim/tb_clk_gen.sv
/*
 * Clock and reset source for the shim testbench.
 * Reset is held low for a fixed number of cycles, then released on a rising edge.
 */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_PERIOD_NS = 4,
    parameter int RESET_CYCLES   = 10
)
(
    output logic clk,
    output logic arst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // Release happens on an edge so the DUT leaves reset cleanly
    initial
    begin
        arst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

// File: hdl/host_mem_avalon_shim.sv
/*
 * Top level of the host-memory shim between an AFU and the FIU port.
 * Long AFU bursts go out as FIU-sized chunks through one register stage, and
 * each AFU write burst gets a single write response.
 */
`timescale 1ns/1ps

module host_mem_avalon_shim
    import hmem_pkg::*;
#(
    parameter int FIU_MAX_BURST = 4,
    parameter int TAG_DEPTH     = 16
)
(
    input  logic         clk,
    input  logic         arst_n,
    input  avmm_cmd_t    afu_cmd,
    output logic         afu_waitrequest,
    output avmm_rd_rsp_t afu_rd_rsp,
    output logic         afu_wr_rsp_valid,
    output avmm_cmd_t    fiu_cmd,
    input  logic         fiu_waitrequest,
    input  avmm_rd_rsp_t fiu_rd_rsp,
    input  logic         fiu_wr_rsp_valid
);

    logic      stage_stall;
    logic      tag_full;
    logic      tag_push;
    logic      split_load;
    logic      split_advance;
    logic      last_chunk;
    addr_t     chunk_addr;
    burst_t    chunk_burst;
    avmm_cmd_t chunk_cmd;

    // ========================================
    // Command path
    // ========================================
    shim_ctrl u_ctrl (
        .clk             (clk),
        .arst_n          (arst_n),
        .afu_cmd         (afu_cmd),
        .stage_stall     (stage_stall),
        .tag_full        (tag_full),
        .chunk_addr      (chunk_addr),
        .chunk_burst     (chunk_burst),
        .last_chunk      (last_chunk),
        .afu_waitrequest (afu_waitrequest),
        .split_load      (split_load),
        .split_advance   (split_advance),
        .tag_push        (tag_push),
        .chunk_cmd       (chunk_cmd)
    );

    // The splitter loads from the AFU beat held under waitrequest
    burst_splitter #(
        .FIU_MAX_BURST (FIU_MAX_BURST)
    ) u_splitter (
        .clk           (clk),
        .arst_n        (arst_n),
        .split_load    (split_load),
        .split_advance (split_advance),
        .load_addr     (afu_cmd.address),
        .load_burst    (afu_cmd.burstcount),
        .chunk_addr    (chunk_addr),
        .chunk_burst   (chunk_burst),
        .last_chunk    (last_chunk)
    );

    avmm_reg_stage u_reg_stage (
        .clk             (clk),
        .arst_n          (arst_n),
        .in_cmd          (chunk_cmd),
        .fiu_waitrequest (fiu_waitrequest),
        .stall           (stage_stall),
        .out_cmd         (fiu_cmd)
    );

    // ========================================
    // Response path
    // ========================================
    wr_rsp_filter #(
        .TAG_DEPTH (TAG_DEPTH)
    ) u_wr_filter (
        .clk              (clk),
        .arst_n           (arst_n),
        .tag_push         (tag_push),
        .tag_in           (last_chunk),
        .fiu_wr_rsp_valid (fiu_wr_rsp_valid),
        .tag_full         (tag_full),
        .afu_wr_rsp_valid (afu_wr_rsp_valid)
    );

    // Read data returns in order, so it needs no tracking
    assign afu_rd_rsp = fiu_rd_rsp;

endmodule

// File: hdl/shim_ctrl.sv
/*
 * Chunk sequencing FSM of the shim. It looks at the pending AFU command,
 * loads the splitter, then issues FIU-sized read chunks or forwards write
 * beats with a burstcount stamped on each chunk's first beat.
 */
`timescale 1ns/1ps

module shim_ctrl
    import hmem_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  avmm_cmd_t afu_cmd,
    input  logic      stage_stall,
    input  logic      tag_full,
    input  addr_t     chunk_addr,
    input  burst_t    chunk_burst,
    input  logic      last_chunk,
    output logic      afu_waitrequest,
    output logic      split_load,
    output logic      split_advance,
    output logic      tag_push,
    output avmm_cmd_t chunk_cmd
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    burst_t      beat_cnt;
    burst_t      beat_nxt;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= IDLE;
            beat_cnt <= '0;
        end
        else
        begin
            state    <= state_nxt;
            beat_cnt <= beat_nxt;
        end
    end

    // ========================================
    // Next state and strobes
    // ========================================
    always_comb
    begin
        state_nxt       = state;
        beat_nxt        = beat_cnt;
        afu_waitrequest = 1'b1;
        split_load      = 1'b0;
        split_advance   = 1'b0;
        tag_push        = 1'b0;
        chunk_cmd       = '0;

        case (state)
            IDLE:
            begin
                // The AFU holds its beat under waitrequest, so peek and load
                if (afu_cmd.read || afu_cmd.write)
                begin
                    split_load = 1'b1;
                    state_nxt  = afu_cmd.read ? RD_ISSUE : WR_FIRST;
                end
            end

            RD_ISSUE:
            begin
                // One read chunk per free stage slot
                if (!stage_stall)
                begin
                    chunk_cmd.read       = 1'b1;
                    chunk_cmd.address    = chunk_addr;
                    chunk_cmd.burstcount = chunk_burst;
                    split_advance        = 1'b1;
                    // The AFU read is taken together with the final chunk
                    if (last_chunk)
                    begin
                        afu_waitrequest = 1'b0;
                        state_nxt       = IDLE;
                    end
                end
            end

            WR_FIRST:
            begin
                // A new chunk needs room for its response tag
                afu_waitrequest = stage_stall | tag_full;
                if (afu_cmd.write && !afu_waitrequest)
                begin
                    chunk_cmd.write      = 1'b1;
                    chunk_cmd.address    = chunk_addr;
                    chunk_cmd.burstcount = chunk_burst;
                    chunk_cmd.writedata  = afu_cmd.writedata;
                    tag_push             = 1'b1;
                    beat_nxt             = burst_t'(1);
                    if (chunk_burst == burst_t'(1))
                    begin
                        // Single-beat chunk is done right away
                        split_advance = 1'b1;
                        beat_nxt      = '0;
                        state_nxt     = last_chunk ? IDLE : WR_FIRST;
                    end
                    else
                    begin
                        state_nxt = WR_BEATS;
                    end
                end
            end

            WR_BEATS:
            begin
                afu_waitrequest = stage_stall;
                if (afu_cmd.write && !afu_waitrequest)
                begin
                    chunk_cmd.write      = 1'b1;
                    chunk_cmd.address    = chunk_addr;
                    chunk_cmd.burstcount = chunk_burst;
                    chunk_cmd.writedata  = afu_cmd.writedata;
                    beat_nxt             = beat_cnt + 1'b1;
                    // Chunk boundary
                    if (beat_nxt == chunk_burst)
                    begin
                        split_advance = 1'b1;
                        beat_nxt      = '0;
                        state_nxt     = last_chunk ? IDLE : WR_FIRST;
                    end
                end
            end

            default:
            begin
                state_nxt = IDLE;
            end
        endcase
    end

    // Inside a chunk the forwarded beats stay below the splitter's chunk size
    a_beat_in_chunk : assert property (
        @(posedge clk) disable iff (!arst_n)
        (state == WR_BEATS) |-> (beat_cnt != '0) && (beat_cnt < chunk_burst)
    );

endmodule

// File: hdl/wr_rsp_filter.sv
/*
 * One-bit tag FIFO for write responses. Each write chunk pushes a tag that
 * says whether it ends an AFU burst. FIU responses pop tags in order and only
 * tagged ones reach the AFU.
 */
`timescale 1ns/1ps

module wr_rsp_filter #(
    parameter int TAG_DEPTH = 16
)
(
    input  logic clk,
    input  logic arst_n,
    input  logic tag_push,
    input  logic tag_in,
    input  logic fiu_wr_rsp_valid,
    output logic tag_full,
    output logic afu_wr_rsp_valid
);

    localparam int PTR_W = (TAG_DEPTH > 1) ? $clog2(TAG_DEPTH) : 1;
    localparam int CNT_W = PTR_W + 1;

    logic [TAG_DEPTH-1:0] tags;
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;

    // Pointers and fill level
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (tag_push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(TAG_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (fiu_wr_rsp_valid)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(TAG_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (tag_push && !fiu_wr_rsp_valid)
            begin
                count <= count + 1'b1;
            end
            else if (!tag_push && fiu_wr_rsp_valid)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // Tag storage
    always_ff @(posedge clk)
    begin
        if (tag_push)
        begin
            tags[wr_ptr] <= tag_in;
        end
    end

    assign tag_full = (count == CNT_W'(TAG_DEPTH));

    // Response goes to the AFU in the same cycle it arrives
    assign afu_wr_rsp_valid = fiu_wr_rsp_valid & tags[rd_ptr];

    // Every FIU response must match a chunk that was pushed earlier
    a_rsp_has_tag : assert property (
        @(posedge clk) disable iff (!arst_n)
        fiu_wr_rsp_valid |-> (count != '0)
    );

endmodule

// File: hdl/burst_splitter.sv
/*
 * Running address and remaining beat count of the burst being split.
 * Loaded once per AFU command and advanced after each FIU chunk.
 */
`timescale 1ns/1ps

module burst_splitter
    import hmem_pkg::*;
#(
    parameter int FIU_MAX_BURST = 4
)
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   split_load,
    input  logic   split_advance,
    input  addr_t  load_addr,
    input  burst_t load_burst,
    output addr_t  chunk_addr,
    output burst_t chunk_burst,
    output logic   last_chunk
);

    localparam burst_t MAX_CHUNK = burst_t'(FIU_MAX_BURST);

    addr_t  addr_q;
    burst_t remain_q;

    // Beats still owed to the FIU for the current AFU burst
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            remain_q <= '0;
        end
        else if (split_load)
        begin
            remain_q <= load_burst;
        end
        else if (split_advance)
        begin
            remain_q <= remain_q - chunk_burst;
        end
    end

    // Address of the next chunk moves on by the size just issued
    always_ff @(posedge clk)
    begin
        if (split_load)
        begin
            addr_q <= load_addr;
        end
        else if (split_advance)
        begin
            addr_q <= addr_q + addr_t'(chunk_burst);
        end
    end

    assign chunk_addr  = addr_q;
    assign chunk_burst = (remain_q > MAX_CHUNK) ? MAX_CHUNK : remain_q;
    // The remainder fits in one FIU burst
    assign last_chunk  = (remain_q <= MAX_CHUNK);

endmodule

// File: hdl/avmm_reg_stage.sv
/*
 * Command register stage at the FIU edge. A main slot drives the FIU and a
 * spare slot catches the beat that arrives while waitrequest is high, so the
 * stall back to the producer comes straight from a flop.
 */
`timescale 1ns/1ps

module avmm_reg_stage
    import hmem_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  avmm_cmd_t in_cmd,
    input  logic      fiu_waitrequest,
    output logic      stall,
    output avmm_cmd_t out_cmd
);

    logic      in_vld;
    logic      out_fire;
    logic      main_vld;
    logic      spare_vld;
    avmm_cmd_t main_cmd;
    avmm_cmd_t spare_cmd;

    // The producer only drives a beat while stall is low
    assign in_vld   = in_cmd.read | in_cmd.write;
    assign out_fire = main_vld & ~fiu_waitrequest;

    // A full spare slot is the only reason to refuse a beat
    assign stall = spare_vld;

    // Slot occupancy
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            main_vld  <= 1'b0;
            spare_vld <= 1'b0;
        end
        else if (spare_vld)
        begin
            // Draining the spare refills main, so main stays occupied
            if (out_fire)
            begin
                spare_vld <= 1'b0;
            end
        end
        else if (in_vld)
        begin
            // Main is held by waitrequest, so the new beat lands in the spare
            if (main_vld && !out_fire)
            begin
                spare_vld <= 1'b1;
            end
            main_vld <= 1'b1;
        end
        else if (out_fire)
        begin
            main_vld <= 1'b0;
        end
    end

    // Beat payload follows the same decisions as the occupancy flags
    always_ff @(posedge clk)
    begin
        if (spare_vld)
        begin
            if (out_fire)
            begin
                main_cmd <= spare_cmd;
            end
        end
        else if (in_vld)
        begin
            if (main_vld && !out_fire)
            begin
                spare_cmd <= in_cmd;
            end
            else
            begin
                main_cmd <= in_cmd;
            end
        end
    end

    // Strobes toward the FIU are qualified by the main slot flag
    always_comb
    begin
        out_cmd       = main_cmd;
        out_cmd.read  = main_cmd.read & main_vld;
        out_cmd.write = main_cmd.write & main_vld;
    end

endmodule

// File: hdl/hmem_pkg.sv
/*
 * Shared widths, vector types and bus structs for the host-memory shim.
 * Modules pull these in with a wildcard import in their header.
 */
package hmem_pkg;

    // ========================================
    // Widths
    // ========================================
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 64;
    localparam int BURST_W = 8;

    // One beat occupies one line address
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;

    // Burst counts run from 1 up to 2^(BURST_W-1) beats
    typedef logic [BURST_W-1:0] burst_t;

    // ========================================
    // Avalon-MM beats
    // ========================================

    // One command beat; burstcount matters on a read and on the first write beat
    typedef struct packed {
        logic   read;
        logic   write;
        addr_t  address;
        burst_t burstcount;
        data_t  writedata;
    } avmm_cmd_t;

    typedef struct packed {
        logic  readdatavalid;
        data_t readdata;
    } avmm_rd_rsp_t;

    // Chunk sequencing states of the control FSM
    typedef enum logic [1:0] {
        IDLE,
        RD_ISSUE,
        WR_FIRST,
        WR_BEATS
    } ctrl_state_t;

endpackage
